// ==== sim.f ====
common/bgpu_pkg.sv
common/bgpu_inst_pkg.sv
common/frontend_if.sv
fetcher/warp_fetcher.sv
logic/inst_mem.sv
logic/decoder.sv
logic/issue_buffer.sv
logic/bgpu_frontend.sv
tests/bgpu_frontend_props.sv
tests/tb_bgpu_frontend.sv

// ==== Bender.yml ====
package:
  name: bgpu_frontend

dependencies: {}

sources:
  # Packages and interfaces first
  - common/bgpu_pkg.sv
  - common/bgpu_inst_pkg.sv
  - common/frontend_if.sv
  # Front-end blocks
  - fetcher/warp_fetcher.sv
  - logic/inst_mem.sv
  - logic/decoder.sv
  - logic/issue_buffer.sv
  - logic/bgpu_frontend.sv
  # Testbench and bound assertions
  - target: test
    files:
      - tests/bgpu_frontend_props.sv
      - tests/tb_bgpu_frontend.sv

// ==== tests/tb_bgpu_frontend.sv ====
/*
 * Directed testbench for the GPU front end: loads programs, starts warps and
 * matches every issued instruction against a per-warp expected stream
 */
`timescale 1ns/100ps
`default_nettype none

module tb_bgpu_frontend import bgpu_pkg::*, bgpu_inst_pkg::*; ();

    localparam int ClkPeriod  = 20;
    localparam int DriveDelay = 2;
    // Single 6, stop first 1, four warps 4 x 5, back-pressure 2 x 10
    localparam int TotalWords     = 6 + 1 + 20 + 20;
    localparam int WatchdogCycles = TotalWords * 20 + 200;
    // Cycles a warp may take to retire its stop word once its stream has issued
    localparam int StopCycles     = 10;

    typedef struct packed {
        pc_t        pc;
        act_mask_t  mask;
        bgpu_inst_t opcode;
        reg_idx_t   dst;
        reg_idx_t   op0;
        reg_idx_t   op1;
    } expected_inst_t;

    logic                clk_i;
    logic                reset_i;
    logic                prog_we_i;
    pc_t                 prog_addr_i;
    enc_inst_t           prog_data_i;
    logic                start_i;
    wid_t                start_warp_id_i;
    pc_t                 start_pc_i;
    act_mask_t           start_mask_i;
    logic [NumWarps-1:0] warp_busy_o;
    logic                issue_valid_o;
    logic                issue_ready_i;
    pc_t                 issue_pc_o;
    act_mask_t           issue_mask_o;
    wid_t                issue_warp_id_o;
    bgpu_inst_t          issue_opcode_o;
    reg_idx_t            issue_dst_o;
    reg_idx_t            issue_op0_o;
    reg_idx_t            issue_op1_o;

    enc_inst_t      prog_model [ImemDepth];
    expected_inst_t exp_q [NumWarps][$];
    bgpu_inst_t     alu_ops [6] = '{ADD, SUB, MUL, AND_OP, OR_OP, LDI};

    integer seed = 32'ha82;
    int     errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    logic   stall_en;
    logic   stalled;

    logic [$bits(expected_inst_t)+$bits(wid_t)-1:0] issue_view;
    logic [$bits(expected_inst_t)+$bits(wid_t)-1:0] held_view;

    assign issue_view = {issue_pc_o, issue_mask_o, issue_opcode_o, issue_dst_o,
                         issue_op0_o, issue_op1_o, issue_warp_id_o};

    bgpu_frontend dut0 (.*);

    initial begin : clock_gen
        clk_i = 1'b0;
        forever begin
            #(ClkPeriod / 2);
            clk_i = ~clk_i;
        end
    end

    initial begin : watchdog
        #(WatchdogCycles * ClkPeriod);
        $display("timeout: the tests did not finish within %0d cycles", WatchdogCycles);
        $display("Simulation failed");
        $finish;
    end

    // Random issue stalls, about three cycles in four
    initial begin : ready_driver
        forever begin
            @(posedge clk_i);
            #DriveDelay;
            issue_ready_i = stall_en ? (($random(seed) & 3) == 0) : 1'b1;
        end
    end

    task automatic check_inst(input wid_t wid, input pc_t pc, input act_mask_t mask,
                              input bgpu_inst_t opcode, input reg_idx_t dst,
                              input reg_idx_t op0, input reg_idx_t op1);
        expected_inst_t e;
        if (exp_q[wid].size() == 0) begin
            $display("warp %0d issued pc %0h at %0t although nothing was expected",
                     wid, pc, $time);
            errors++;
        end else begin
            e = exp_q[wid].pop_front();
            if (pc !== e.pc || mask !== e.mask || opcode !== e.opcode ||
                    dst !== e.dst || op0 !== e.op0 || op1 !== e.op1) begin
                $display("error at %0t: warp %0d got pc %h mask %h %s %h %h %h",
                         $time, wid, pc, mask, opcode.name(), dst, op0, op1);
                $display("error at %0t: warp %0d expected pc %h mask %h %s %h %h %h",
                         $time, wid, e.pc, e.mask, e.opcode.name(), e.dst, e.op0, e.op1);
                errors++;
            end
        end
    endtask

    task automatic check_busy(input logic [NumWarps-1:0] exp);
        if (warp_busy_o !== exp) begin
            $display("error at %0t: warp_busy_o is %b, expected %b", $time, warp_busy_o, exp);
            errors++;
        end
    endtask

    task automatic check_valid(input logic exp);
        if (issue_valid_o !== exp) begin
            $display("error at %0t: issue_valid_o is %b, expected %b",
                     $time, issue_valid_o, exp);
            errors++;
        end
    endtask

    // Issue port transfers complete at the next rising edge
    always @(negedge clk_i) begin : issue_monitor
        if (reset_i) begin
            stalled = 1'b0;
        end else begin
            if (stalled && (!issue_valid_o || issue_view !== held_view)) begin
                $display("error at %0t: issue output changed while stalled", $time);
                errors++;
            end
            if (issue_valid_o && issue_ready_i) begin
                check_inst(issue_warp_id_o, issue_pc_o, issue_mask_o, issue_opcode_o,
                           issue_dst_o, issue_op0_o, issue_op1_o);
            end
            stalled   = issue_valid_o && !issue_ready_i;
            held_view = issue_view;
        end
    end

    // Writes n_alu random ALU words followed by a stop word
    task automatic load_program(input pc_t base, input int unsigned n_alu);
        enc_inst_t   word;
        int unsigned pick;
        for (int unsigned i = 0; i <= n_alu; i++) begin
            word = $random(seed);
            pick = $unsigned($random(seed)) % 6;
            word[31:24] = (i == n_alu) ? 8'hff : alu_ops[pick];
            @(posedge clk_i);
            #DriveDelay;
            prog_we_i   = 1'b1;
            prog_addr_i = base + pc_t'(i);
            prog_data_i = word;
            prog_model[base + pc_t'(i)] = word;
        end
        @(posedge clk_i);
        #DriveDelay;
        prog_we_i = 1'b0;
    endtask

    task automatic start_warp(input wid_t wid, input pc_t pc, input act_mask_t mask);
        expected_inst_t e;
        pc_t            p;
        p = pc;
        while (prog_model[p][31:24] != 8'hff) begin
            e.pc     = p;
            e.mask   = mask;
            e.opcode = bgpu_inst_t'(prog_model[p][31:24]);
            e.dst    = prog_model[p][7:0];
            e.op0    = prog_model[p][15:8];
            e.op1    = prog_model[p][23:16];
            exp_q[wid].push_back(e);
            p++;
        end
        @(posedge clk_i);
        #DriveDelay;
        start_i         = 1'b1;
        start_warp_id_i = wid;
        start_pc_i      = pc;
        start_mask_i    = mask;
        @(posedge clk_i);
        #DriveDelay;
        start_i = 1'b0;
    endtask

    function automatic int unsigned pending_count();
        int unsigned n;
        n = 0;
        for (int w = 0; w < NumWarps; w++) begin
            n += exp_q[w].size();
        end
        return n;
    endfunction

    // Extra cycles at the end give stray issues a chance to show
    task automatic wait_drained();
        int n;
        @(negedge clk_i);
        while (pending_count() != 0) begin
            @(negedge clk_i);
        end
        // Stop words still have to retire, but only for a bounded time
        n = 0;
        while (warp_busy_o != '0 && n < StopCycles) begin
            @(negedge clk_i);
            n++;
        end
        repeat (4) @(negedge clk_i);
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic test_reset();
        int start_errors;
        start_errors = errors;
        @(negedge clk_i);
        check_valid(1'b0);
        check_busy('0);
        report_test("reset state", start_errors);
    endtask

    task automatic test_single();
        int start_errors;
        start_errors = errors;
        load_program(8'h00, 5);
        start_warp(2'd0, 8'h00, 8'hff);
        check_busy(4'b0001);
        wait_drained();
        check_busy('0);
        report_test("single warp", start_errors);
    endtask

    task automatic test_stop_first();
        int start_errors;
        start_errors = errors;
        load_program(8'h10, 0);
        start_warp(2'd2, 8'h10, 8'h55);
        check_busy(4'b0100);
        wait_drained();
        check_busy('0);
        report_test("stop first", start_errors);
    endtask

    task automatic test_four_warps();
        int start_errors;
        start_errors = errors;
        load_program(8'h20, 4);
        load_program(8'h40, 4);
        load_program(8'h60, 4);
        load_program(8'h80, 4);
        start_warp(2'd0, 8'h20, 8'h01);
        start_warp(2'd1, 8'h40, 8'h0f);
        start_warp(2'd2, 8'h60, 8'hf0);
        start_warp(2'd3, 8'h80, 8'haa);
        wait_drained();
        check_busy('0);
        report_test("four warps", start_errors);
    endtask

    task automatic test_back_pressure();
        int start_errors;
        start_errors = errors;
        load_program(8'ha0, 9);
        load_program(8'hc0, 9);
        @(negedge clk_i);
        stall_en = 1'b1;
        start_warp(2'd1, 8'ha0, 8'h3c);
        start_warp(2'd3, 8'hc0, 8'hc3);
        wait_drained();
        stall_en = 1'b0;
        check_busy('0);
        report_test("back-pressure", start_errors);
    endtask

    initial begin : main
        reset_i         = 1'b1;
        prog_we_i       = 1'b0;
        prog_addr_i     = '0;
        prog_data_i     = '0;
        start_i         = 1'b0;
        start_warp_id_i = '0;
        start_pc_i      = '0;
        start_mask_i    = '0;
        issue_ready_i   = 1'b1;
        stall_en        = 1'b0;
        repeat (3) @(posedge clk_i);
        #DriveDelay;
        reset_i = 1'b0;

        test_reset();
        test_single();
        test_stop_first();
        test_four_warps();
        test_back_pressure();

        errors += dut0.props0.fail_count;
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/bgpu_frontend_props.sv ====
/*
 * Concurrent checks on the front-end issue port and reset behavior
 */
`timescale 1ns/100ps
`default_nettype none

module bgpu_frontend_props import bgpu_pkg::*, bgpu_inst_pkg::*; (
    input wire                 clk_i,
    input wire                 reset_i,
    input wire                 issue_valid_i,
    input wire                 issue_ready_i,
    input pc_t                 issue_pc_i,
    input act_mask_t           issue_mask_i,
    input wid_t                issue_warp_id_i,
    input bgpu_inst_t          issue_opcode_i,
    input reg_idx_t            issue_dst_i,
    input reg_idx_t            issue_op0_i,
    input reg_idx_t            issue_op1_i,
    input wire [NumWarps-1:0]  warp_busy_i
);
    int fail_count = 0;

    logic [49:0] issue_data;

    assign issue_data = {issue_pc_i, issue_mask_i, issue_warp_id_i, issue_opcode_i,
                         issue_dst_i, issue_op0_i, issue_op1_i};

    valid_low_after_reset: assert property (
        @(posedge clk_i) reset_i |=> !issue_valid_i
    ) else begin
        $error("issue_valid_o high in the cycle after reset");
        fail_count++;
    end

    // A stalled instruction stays offered with the same fields
    issue_stable_when_stalled: assert property (
        @(posedge clk_i) disable iff (reset_i)
        issue_valid_i && !issue_ready_i |=> issue_valid_i && $stable(issue_data)
    ) else begin
        $error("issue port changed while stalled");
        fail_count++;
    end

    busy_clear_after_reset: assert property (
        @(posedge clk_i) reset_i |=> warp_busy_i == '0
    ) else begin
        $error("warp_busy_o not zero after reset");
        fail_count++;
    end

endmodule

bind bgpu_frontend bgpu_frontend_props props0 (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .issue_valid_i   (issue_valid_o),
    .issue_ready_i   (issue_ready_i),
    .issue_pc_i      (issue_pc_o),
    .issue_mask_i    (issue_mask_o),
    .issue_warp_id_i (issue_warp_id_o),
    .issue_opcode_i  (issue_opcode_o),
    .issue_dst_i     (issue_dst_o),
    .issue_op0_i     (issue_op0_o),
    .issue_op1_i     (issue_op1_o),
    .warp_busy_i     (warp_busy_o)
);

`default_nettype wire

// ==== logic/bgpu_frontend.sv ====
/*
 * GPU compute unit front end: warp fetch, instruction memory, decode, issue
 */
`timescale 1ns/100ps
`default_nettype none

module bgpu_frontend import bgpu_pkg::*, bgpu_inst_pkg::*; (
    input  wire                 clk_i,
    input  wire                 reset_i,

    // Program load
    input  wire                 prog_we_i,
    input  pc_t                 prog_addr_i,
    input  enc_inst_t           prog_data_i,

    // Warp start
    input  wire                 start_i,
    input  wid_t                start_warp_id_i,
    input  pc_t                 start_pc_i,
    input  act_mask_t           start_mask_i,
    output logic [NumWarps-1:0] warp_busy_o,

    // Issue port
    output logic                issue_valid_o,
    input  wire                 issue_ready_i,
    output pc_t                 issue_pc_o,
    output act_mask_t           issue_mask_o,
    output wid_t                issue_warp_id_o,
    output bgpu_inst_t          issue_opcode_o,
    output reg_idx_t            issue_dst_o,
    output reg_idx_t            issue_op0_o,
    output reg_idx_t            issue_op1_o
);
    fetch_req_if fetch_req ();
    inst_if      fetched ();
    dec_inst_if  dec_inst ();
    decoded_if   decoded ();

    warp_fetcher i_fetcher (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .start_i         (start_i),
        .start_warp_id_i (start_warp_id_i),
        .start_pc_i      (start_pc_i),
        .start_mask_i    (start_mask_i),
        .warp_busy_o     (warp_busy_o),
        .fetch_o         (fetch_req.sender),
        .decoded_i       (decoded.receiver)
    );

    inst_mem i_inst_mem (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .prog_we_i   (prog_we_i),
        .prog_addr_i (prog_addr_i),
        .prog_data_i (prog_data_i),
        .fetch_i     (fetch_req.receiver),
        .inst_o      (fetched.sender)
    );

    decoder i_decoder (
        .in_i  (fetched.receiver),
        .out_o (dec_inst.sender),
        .fb_o  (decoded.sender)
    );

    issue_buffer i_issue_buffer (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .in_i            (dec_inst.receiver),
        .issue_valid_o   (issue_valid_o),
        .issue_ready_i   (issue_ready_i),
        .issue_pc_o      (issue_pc_o),
        .issue_mask_o    (issue_mask_o),
        .issue_warp_id_o (issue_warp_id_o),
        .issue_opcode_o  (issue_opcode_o),
        .issue_dst_o     (issue_dst_o),
        .issue_op0_o     (issue_op0_o),
        .issue_op1_o     (issue_op1_o)
    );

endmodule

`default_nettype wire

// ==== logic/issue_buffer.sv ====
/*
 * Issue buffer: small FIFO of decoded instructions ahead of the issue port
 */
`timescale 1ns/100ps
`default_nettype none

module issue_buffer import bgpu_pkg::*, bgpu_inst_pkg::*; (
    input  wire             clk_i,
    input  wire             reset_i,

    dec_inst_if.receiver    in_i,

    output logic            issue_valid_o,
    input  wire             issue_ready_i,
    output pc_t             issue_pc_o,
    output act_mask_t       issue_mask_o,
    output wid_t            issue_warp_id_o,
    output bgpu_inst_t      issue_opcode_o,
    output reg_idx_t        issue_dst_o,
    output reg_idx_t        issue_op0_o,
    output reg_idx_t        issue_op1_o
);
    typedef struct packed {
        pc_t        pc;
        act_mask_t  act_mask;
        wid_t       warp_id;
        bgpu_inst_t opcode;
        reg_idx_t   dst;
        reg_idx_t   [OperandsPerInst-1:0] operands;
    } entry_t;

    entry_t entry_q [IssueDepth];

    logic [$clog2(IssueDepth)-1:0] wr_ptr_q;
    logic [$clog2(IssueDepth)-1:0] rd_ptr_q;
    logic [$clog2(IssueDepth):0]   count_q;

    logic push;
    logic pop;

    assign in_i.ready    = count_q != IssueDepth;
    assign issue_valid_o = count_q != '0;

    assign push = in_i.valid && in_i.ready;
    assign pop  = issue_valid_o && issue_ready_i;

    always_ff @(posedge clk_i) begin : pointers
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + push - pop;
        end
    end

    // Write slot differs from the read slot whenever the FIFO is not empty
    always_ff @(posedge clk_i) begin : storage
        if (push) begin
            entry_q[wr_ptr_q] <= '{
                pc:       in_i.pc,
                act_mask: in_i.act_mask,
                warp_id:  in_i.warp_id,
                opcode:   in_i.opcode,
                dst:      in_i.dst,
                operands: in_i.operands
            };
        end
    end

    assign issue_pc_o      = entry_q[rd_ptr_q].pc;
    assign issue_mask_o    = entry_q[rd_ptr_q].act_mask;
    assign issue_warp_id_o = entry_q[rd_ptr_q].warp_id;
    assign issue_opcode_o  = entry_q[rd_ptr_q].opcode;
    assign issue_dst_o     = entry_q[rd_ptr_q].dst;
    assign issue_op0_o     = entry_q[rd_ptr_q].operands[0];
    assign issue_op1_o     = entry_q[rd_ptr_q].operands[1];

endmodule

`default_nettype wire

// ==== logic/decoder.sv ====
/*
 * Decoder: splits instruction words into fields and reports next PCs
 */
`timescale 1ns/100ps
`default_nettype none

module decoder import bgpu_pkg::*, bgpu_inst_pkg::*; (
    inst_if.receiver   in_i,
    dec_inst_if.sender out_o,
    decoded_if.sender  fb_o
);
    logic stop_warp;

    assign stop_warp = in_i.inst[OpcodeMsb:OpcodeLsb] == STOP;

    // Stop words never wait on the issue buffer
    assign in_i.ready = out_o.ready || stop_warp;

    // Metadata travels alongside the instruction
    assign out_o.pc       = in_i.pc;
    assign out_o.act_mask = in_i.act_mask;
    assign out_o.warp_id  = in_i.warp_id;

    always_comb begin : decode
        out_o.valid       = in_i.valid && !stop_warp;
        out_o.opcode      = bgpu_inst_t'(in_i.inst[OpcodeMsb:OpcodeLsb]);
        out_o.dst         = in_i.inst[DstMsb:DstLsb];
        out_o.operands[0] = in_i.inst[Op0Msb:Op0Lsb];
        out_o.operands[1] = in_i.inst[Op1Msb:Op1Lsb];
    end

    // Feedback fires once per consumed word, issued or stopped
    assign fb_o.decoded   = (in_i.valid && stop_warp) || (out_o.valid && out_o.ready);
    assign fb_o.stop_warp = stop_warp;
    assign fb_o.warp_id   = in_i.warp_id;
    assign fb_o.next_pc   = in_i.pc + pc_t'(1);

endmodule

`default_nettype wire

// ==== logic/inst_mem.sv ====
/*
 * Instruction memory: program RAM with a registered, flow-controlled read stage
 */
`timescale 1ns/100ps
`default_nettype none

module inst_mem import bgpu_pkg::*, bgpu_inst_pkg::*; (
    input  wire          clk_i,
    input  wire          reset_i,

    input  wire          prog_we_i,
    input  pc_t          prog_addr_i,
    input  enc_inst_t    prog_data_i,

    fetch_req_if.receiver fetch_i,
    inst_if.sender        inst_o
);
    enc_inst_t mem_q [ImemDepth];

    logic      out_valid_q;
    pc_t       out_pc_q;
    act_mask_t out_mask_q;
    wid_t      out_wid_q;
    enc_inst_t out_inst_q;

    // Output register is free or drains this cycle
    assign fetch_i.ready = !out_valid_q || inst_o.ready;

    always_ff @(posedge clk_i) begin : out_valid
        if (reset_i) begin
            out_valid_q <= 1'b0;
        end else if (fetch_i.ready) begin
            out_valid_q <= fetch_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin : ram
        if (prog_we_i) begin
            mem_q[prog_addr_i] <= prog_data_i;
        end
        if (fetch_i.valid && fetch_i.ready) begin
            out_inst_q <= mem_q[fetch_i.pc];
            out_pc_q   <= fetch_i.pc;
            out_mask_q <= fetch_i.act_mask;
            out_wid_q  <= fetch_i.warp_id;
        end
    end

    assign inst_o.valid    = out_valid_q;
    assign inst_o.pc       = out_pc_q;
    assign inst_o.act_mask = out_mask_q;
    assign inst_o.warp_id  = out_wid_q;
    assign inst_o.inst     = out_inst_q;

endmodule

`default_nettype wire

// ==== fetcher/warp_fetcher.sv ====
/*
 * Warp fetcher: per-warp PC table with a round-robin pick of ready warps
 */
`timescale 1ns/100ps
`default_nettype none

module warp_fetcher import bgpu_pkg::*; (
    input  wire                clk_i,
    input  wire                reset_i,

    input  wire                start_i,
    input  wid_t               start_warp_id_i,
    input  pc_t                start_pc_i,
    input  act_mask_t          start_mask_i,
    output logic [NumWarps-1:0] warp_busy_o,

    fetch_req_if.sender        fetch_o,
    decoded_if.receiver        decoded_i
);
    warp_state_e state_q [NumWarps];
    pc_t         pc_q    [NumWarps];
    act_mask_t   mask_q  [NumWarps];

    wid_t last_q;
    logic lock_q;
    wid_t lock_wid_q;

    logic sel_valid;
    wid_t sel_wid;
    logic fetch_fire;

    // Round-robin search starting after the last granted warp
    always_comb begin : arbiter
        wid_t idx;
        sel_valid = 1'b0;
        sel_wid   = last_q;
        for (int unsigned i = 1; i <= NumWarps; i++) begin
            idx = last_q + wid_t'(i);
            if (!sel_valid && state_q[idx] == READY) begin
                sel_valid = 1'b1;
                sel_wid   = idx;
            end
        end
        // A stalled request keeps its warp until it transfers
        if (lock_q) begin
            sel_valid = 1'b1;
            sel_wid   = lock_wid_q;
        end
    end

    assign fetch_o.valid    = sel_valid;
    assign fetch_o.pc       = pc_q[sel_wid];
    assign fetch_o.act_mask = mask_q[sel_wid];
    assign fetch_o.warp_id  = sel_wid;

    assign fetch_fire = fetch_o.valid && fetch_o.ready;

    always_comb begin : busy
        for (int unsigned w = 0; w < NumWarps; w++) begin
            warp_busy_o[w] = state_q[w] != IDLE;
        end
    end

    // Start, fetch and feedback always touch different warps
    always_ff @(posedge clk_i) begin : state_table
        if (reset_i) begin
            for (int unsigned w = 0; w < NumWarps; w++) begin
                state_q[w] <= IDLE;
            end
            last_q <= '0;
            lock_q <= 1'b0;
        end else begin
            if (start_i && state_q[start_warp_id_i] == IDLE) begin
                state_q[start_warp_id_i] <= READY;
            end
            if (fetch_fire) begin
                state_q[sel_wid] <= WAITING;
                last_q           <= sel_wid;
            end
            if (decoded_i.decoded) begin
                state_q[decoded_i.warp_id] <= decoded_i.stop_warp ? IDLE : READY;
            end
            lock_q <= fetch_o.valid && !fetch_o.ready;
        end
    end

    always_ff @(posedge clk_i) begin : pc_table
        if (start_i && state_q[start_warp_id_i] == IDLE) begin
            pc_q[start_warp_id_i]   <= start_pc_i;
            mask_q[start_warp_id_i] <= start_mask_i;
        end
        if (decoded_i.decoded) begin
            pc_q[decoded_i.warp_id] <= decoded_i.next_pc;
        end
        lock_wid_q <= sel_wid;
    end

endmodule

`default_nettype wire

// ==== common/frontend_if.sv ====
/*
 * Front-end links: fetch request, fetched instruction, decoded instruction
 * and the decoder's next-PC feedback to the fetcher
 */
`timescale 1ns/100ps
`default_nettype none

// Fetcher to instruction memory
interface fetch_req_if import bgpu_pkg::*; ();
    logic      valid;
    logic      ready;
    pc_t       pc;
    act_mask_t act_mask;
    wid_t      warp_id;

    modport sender (output valid, pc, act_mask, warp_id, input ready);
    modport receiver (input valid, pc, act_mask, warp_id, output ready);
endinterface

// Instruction memory to decoder
interface inst_if import bgpu_pkg::*, bgpu_inst_pkg::*; ();
    logic      valid;
    logic      ready;
    pc_t       pc;
    act_mask_t act_mask;
    wid_t      warp_id;
    enc_inst_t inst;

    modport sender (output valid, pc, act_mask, warp_id, inst, input ready);
    modport receiver (input valid, pc, act_mask, warp_id, inst, output ready);
endinterface

// Decoder to issue buffer
interface dec_inst_if import bgpu_pkg::*, bgpu_inst_pkg::*; ();
    logic       valid;
    logic       ready;
    pc_t        pc;
    act_mask_t  act_mask;
    wid_t       warp_id;
    bgpu_inst_t opcode;
    reg_idx_t   dst;
    reg_idx_t   [OperandsPerInst-1:0] operands;

    modport sender (
        output valid, pc, act_mask, warp_id, opcode, dst, operands,
        input  ready
    );
    modport receiver (
        input  valid, pc, act_mask, warp_id, opcode, dst, operands,
        output ready
    );
endinterface

// Decoder feedback to the fetcher, no back-pressure
interface decoded_if import bgpu_pkg::*; ();
    logic decoded;
    logic stop_warp;
    wid_t warp_id;
    pc_t  next_pc;

    modport sender (output decoded, stop_warp, warp_id, next_pc);
    modport receiver (input decoded, stop_warp, warp_id, next_pc);
endinterface

`default_nettype wire

// ==== common/bgpu_inst_pkg.sv ====
/*
 * Instruction encoding of the GPU front end: opcodes and field positions
 */
`default_nettype none

package bgpu_inst_pkg;

    localparam int unsigned EncInstWidth = 32;

    // Field positions inside an encoded word
    localparam int unsigned DstLsb    = 0;
    localparam int unsigned DstMsb    = 7;
    localparam int unsigned Op0Lsb    = 8;
    localparam int unsigned Op0Msb    = 15;
    localparam int unsigned Op1Lsb    = 16;
    localparam int unsigned Op1Msb    = 23;
    localparam int unsigned OpcodeLsb = 24;
    localparam int unsigned OpcodeMsb = 31;

    typedef logic [EncInstWidth-1:0] enc_inst_t;

    // All ones ends a warp
    typedef enum logic [OpcodeMsb-OpcodeLsb:0] {
        ADD    = 8'h00,
        SUB    = 8'h01,
        MUL    = 8'h02,
        AND_OP = 8'h03,
        OR_OP  = 8'h04,
        LDI    = 8'h05,
        STOP   = 8'hff
    } bgpu_inst_t;

endpackage

`default_nettype wire

// ==== common/bgpu_pkg.sv ====
/*
 * GPU front-end sizes and the basic warp, PC, mask and register index types
 */
`default_nettype none

package bgpu_pkg;

    // Compute unit dimensions
    localparam int unsigned NumWarps    = 4;
    localparam int unsigned WarpWidth   = 8;
    localparam int unsigned PcWidth     = 8;
    localparam int unsigned RegIdxWidth = 8;

    // Program storage in words
    localparam int unsigned ImemDepth = 256;

    // Derived widths and counts
    localparam int unsigned WidWidth        = $clog2(NumWarps);
    localparam int unsigned OperandsPerInst = 2;
    localparam int unsigned IssueDepth      = 2;

    typedef logic [WidWidth-1:0]    wid_t;
    typedef logic [PcWidth-1:0]     pc_t;
    typedef logic [WarpWidth-1:0]   act_mask_t;
    typedef logic [RegIdxWidth-1:0] reg_idx_t;

    // Scheduling state of one warp
    typedef enum logic [1:0] {
        IDLE,
        READY,
        WAITING
    } warp_state_e;

endpackage

`default_nettype wire
